// ==== Bender.yml ====
package:
  name: ocl_cfg_bridge

sources:
  # bridge RTL, package first
  - include_dirs:
      - logic
    files:
      - logic/ocl_bridge_pkg.sv
      - logic/ocl_bridge_if.sv
      - logic/axil_reg_slice.sv
      - logic/ocl_slave_fsm.sv
      - logic/cfg_slot_dispatch.sv
      - logic/ocl_cfg_bridge.sv

  # simulation only
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_ocl_cfg_bridge.sv

// ==== logic/axil_reg_slice.sv ====
// axil_reg_slice: one-deep register stage on each axi4-lite channel
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

module axil_reg_slice (
  input wire   clk,
  input wire   reset,
  axil_if.sub  s,  // host side
  axil_if.mgr  m   // fsm side
);

  localparam int NCH = 5;
  localparam int PW  = `CFG_DATA_W + 2; // widest payload is rdata + rresp

  // channel slots
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;
  localparam int CH_B  = 3;
  localparam int CH_R  = 4;

  logic [NCH-1:0] in_valid;  // upstream valid per channel
  logic [NCH-1:0] out_ready; // downstream ready per channel
  logic [NCH-1:0] full;      // stage holds an item
  logic [PW-1:0]  in_data [NCH];
  logic [PW-1:0]  stage_q [NCH];
  logic           live_q;    // stages open one cycle after reset releases

  // gather the five channels into arrays
  always_comb begin
    in_valid[CH_AW]  = s.awvalid;
    in_valid[CH_W]   = s.wvalid;
    in_valid[CH_AR]  = s.arvalid;
    in_valid[CH_B]   = m.bvalid;
    in_valid[CH_R]   = m.rvalid;
    out_ready[CH_AW] = m.awready;
    out_ready[CH_W]  = m.wready;
    out_ready[CH_AR] = m.arready;
    out_ready[CH_B]  = s.bready;
    out_ready[CH_R]  = s.rready;
    in_data[CH_AW]   = {2'b00, s.awaddr};
    in_data[CH_W]    = {2'b00, s.wdata};
    in_data[CH_AR]   = {2'b00, s.araddr};
    in_data[CH_B]    = {{`CFG_DATA_W{1'b0}}, m.bresp};
    in_data[CH_R]    = {m.rdata, m.rresp};
  end

  // ------------------------------------------------------------
  // full flags, accept when empty, release on downstream ready
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      full   <= '0;
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      for (int i = 0; i < NCH; i++) begin
        if (!full[i] && in_valid[i] && live_q)
          full[i] <= 1'b1;
        else if (full[i] && out_ready[i])
          full[i] <= 1'b0; // item handed on
      end
    end
  end

  // payload, only written into an empty stage so it stays put under stall
  always_ff @(posedge clk) begin
    for (int i = 0; i < NCH; i++) begin
      if (!full[i] && in_valid[i] && live_q)
        stage_q[i] <= in_data[i];
    end
  end

  // ready only when empty, so one transfer every two cycles
  assign s.awready = !full[CH_AW] && live_q;
  assign s.wready  = !full[CH_W] && live_q;
  assign s.arready = !full[CH_AR] && live_q;
  assign m.bready  = !full[CH_B] && live_q;
  assign m.rready  = !full[CH_R] && live_q;

  assign m.awvalid = full[CH_AW];
  assign m.awaddr  = stage_q[CH_AW][`CFG_DATA_W-1:0];
  assign m.wvalid  = full[CH_W];
  assign m.wdata   = stage_q[CH_W][`CFG_DATA_W-1:0];
  assign m.arvalid = full[CH_AR];
  assign m.araddr  = stage_q[CH_AR][`CFG_DATA_W-1:0];
  assign s.bvalid  = full[CH_B];
  assign s.bresp   = stage_q[CH_B][1:0];
  assign s.rvalid  = full[CH_R];
  assign s.rdata   = stage_q[CH_R][PW-1:2];
  assign s.rresp   = stage_q[CH_R][1:0];

  // a held item stays, unchanged, until it is taken
  for (genvar g = 0; g < NCH; g++) begin : g_hold_chk
    a_valid_hold: assert property (@(posedge clk) disable iff (reset)
      full[g] && !out_ready[g] |=> full[g] && $stable(stage_q[g]));
  end

endmodule

`default_nettype wire

// ==== logic/cfg_slot_dispatch.sv ====
// cfg_slot_dispatch: slot decode, per-slot strobes, ack and read data select
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

module cfg_slot_dispatch (
  input wire                                      clk,
  input wire                                      reset,
  cfg_req_if.tgt                                  req,
  output logic [`CFG_DATA_W-1:0]                  cfg_addr,  // shared by all slots
  output logic [`CFG_DATA_W-1:0]                  cfg_wdata,
  output logic [`CFG_NUM_SLOTS-1:0]               cfg_wr,
  output logic [`CFG_NUM_SLOTS-1:0]               cfg_rd,
  input wire   [`CFG_NUM_SLOTS-1:0]               cfg_ack,
  input wire   [`CFG_NUM_SLOTS*`CFG_DATA_W-1:0]   cfg_rdata  // slot 0 in the low word
);

  localparam int SEL_W = (`CFG_NUM_SLOTS > 1) ? $clog2(`CFG_NUM_SLOTS) : 1;

  logic             mapped;  // window has a target behind it
  logic [SEL_W-1:0] sel;     // slot index into ack/rdata
  logic             unm_ack; // local ack for an empty window

  assign mapped = req.addr.fields.slot < `CFG_SLOT_W'(`CFG_NUM_SLOTS);
  assign sel    = req.addr.fields.slot[SEL_W-1:0];

  // ------------------------------------------------------------
  // strobes, one cycle after the request, selected slot only
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_wr  <= '0;
      cfg_rd  <= '0;
      unm_ack <= 1'b0;
    end else begin
      for (int i = 0; i < `CFG_NUM_SLOTS; i++) begin
        cfg_wr[i] <= req.req_wr && (req.addr.fields.slot == `CFG_SLOT_W'(i));
        cfg_rd[i] <= req.req_rd && (req.addr.fields.slot == `CFG_SLOT_W'(i));
      end
      unm_ack <= (req.req_wr || req.req_rd) && !mapped; // write dropped here
    end
  end

  // address and data copy, stable while the target answers
  always_ff @(posedge clk) begin
    if (req.req_wr || req.req_rd) begin
      cfg_addr  <= req.addr.raw;
      cfg_wdata <= req.wdata;
    end
  end

  // target ack passes straight through
  assign req.ack   = mapped ? cfg_ack[sel] : unm_ack;
  assign req.rdata = mapped ? cfg_rdata[sel*`CFG_DATA_W +: `CFG_DATA_W]
                            : `CFG_UNMAPPED_RDATA;

  // at most one strobe across all slots and both directions
  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    $onehot0({cfg_wr, cfg_rd}));

endmodule

`default_nettype wire

// ==== logic/ocl_bridge_cfg.svh ====
// width, slot count, slot shift and unmapped read pattern macros for the ocl bridge
`ifndef OCL_BRIDGE_CFG_SVH
`define OCL_BRIDGE_CFG_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------
`define CFG_DATA_W 32 // data word and address word

// ------------------------------------------------------------
// target windows, 256 bytes each
// ------------------------------------------------------------
`define CFG_NUM_SLOTS 4   // implemented targets
`define CFG_SLOT_SHIFT 8  // log2 of window size
`define CFG_SLOT_W 17     // window select, addr[24:8]

// returned for a read that hits no target
`define CFG_UNMAPPED_RDATA 32'hdead_beef

`endif

// ==== logic/ocl_bridge_if.sv ====
// axil_if and cfg_req_if bundles with their modports
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

// ------------------------------------------------------------
// axi4-lite, five channels, no ids, prot or strobes
// ------------------------------------------------------------
interface axil_if;
  logic [`CFG_DATA_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [`CFG_DATA_W-1:0] wdata;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [`CFG_DATA_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [`CFG_DATA_W-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;

  // request side, drives aw/w/ar and takes b/r
  modport mgr (
    output awaddr, awvalid, input awready,
    output wdata, wvalid, input wready,
    input bresp, bvalid, output bready,
    output araddr, arvalid, input arready,
    input rdata, rresp, rvalid, output rready
  );

  // answering side
  modport sub (
    input awaddr, awvalid, output awready,
    input wdata, wvalid, output wready,
    output bresp, bvalid, input bready,
    input araddr, arvalid, output arready,
    output rdata, rresp, rvalid, input rready
  );
endinterface

// ------------------------------------------------------------
// one access at a time from the fsm to the slot decoder
// ------------------------------------------------------------
interface cfg_req_if;
  import ocl_bridge_pkg::*;

  ocl_addr_u              addr;   // held for the whole access
  logic [`CFG_DATA_W-1:0] wdata;
  logic                   req_wr; // one-cycle pulse
  logic                   req_rd; // one-cycle pulse
  logic                   ack;    // ends the access
  logic [`CFG_DATA_W-1:0] rdata;  // valid with ack

  modport fsm (output addr, wdata, req_wr, req_rd, input ack, rdata);
  modport tgt (input addr, wdata, req_wr, req_rd, output ack, rdata);
endinterface

`default_nettype wire

// ==== logic/ocl_bridge_pkg.sv ====
// ocl_bridge_pkg: address union, slave state enum, response code
`default_nettype none

`include "ocl_bridge_cfg.svh"

package ocl_bridge_pkg;

  // one address word, seen whole or split into window fields
  typedef union packed {
    logic [`CFG_DATA_W-1:0] raw; // as latched from aw/ar
    struct packed {
      logic [`CFG_DATA_W-`CFG_SLOT_W-`CFG_SLOT_SHIFT-1:0] upper; // ignored bits
      logic [`CFG_SLOT_W-1:0] slot;       // target window
      logic [`CFG_SLOT_SHIFT-1:0] offset; // byte inside the window
    } fields;
  } ocl_addr_u;

  // access state machine
  typedef enum logic [1:0] {
    SLV_IDLE    = 2'd0, // waiting for aw or ar
    SLV_WR_ADDR = 2'd1, // write address taken
    SLV_CYC     = 2'd2, // request out, waiting for ack
    SLV_RESP    = 2'd3  // b or r held until accepted
  } slv_state_e;

  localparam logic [1:0] RESP_OKAY = 2'b00; // only response this bridge gives

endpackage

`default_nettype wire

// ==== logic/ocl_cfg_bridge.sv ====
// ocl_cfg_bridge: top level, axi4-lite host ports to configuration bus ports
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

module ocl_cfg_bridge (
  input wire                                        clk,
  input wire                                        reset,
  // axi4-lite from the host
  input wire   [`CFG_DATA_W-1:0]                    awaddr,
  input wire                                        awvalid,
  output logic                                      awready,
  input wire   [`CFG_DATA_W-1:0]                    wdata,
  input wire                                        wvalid,
  output logic                                      wready,
  output logic [$bits(ocl_bridge_pkg::RESP_OKAY)-1:0] bresp,
  output logic                                      bvalid,
  input wire                                        bready,
  input wire   [`CFG_DATA_W-1:0]                    araddr,
  input wire                                        arvalid,
  output logic                                      arready,
  output logic [`CFG_DATA_W-1:0]                    rdata,
  output logic [$bits(ocl_bridge_pkg::RESP_OKAY)-1:0] rresp,
  output logic                                      rvalid,
  input wire                                        rready,
  // configuration bus to the targets
  output logic [`CFG_DATA_W-1:0]                    cfg_addr,
  output logic [`CFG_DATA_W-1:0]                    cfg_wdata,
  output logic [`CFG_NUM_SLOTS-1:0]                 cfg_wr,
  output logic [`CFG_NUM_SLOTS-1:0]                 cfg_rd,
  input wire   [`CFG_NUM_SLOTS-1:0]                 cfg_ack,
  input wire   [`CFG_NUM_SLOTS*`CFG_DATA_W-1:0]     cfg_rdata
);

  axil_if    host_bus ();  // host ports, bundled
  axil_if    slice_bus (); // slice to fsm
  cfg_req_if req_bus ();   // fsm to slot decoder

  // ------------------------------------------------------------
  // host ports onto the bundle
  // ------------------------------------------------------------
  assign host_bus.awaddr  = awaddr;
  assign host_bus.awvalid = awvalid;
  assign awready          = host_bus.awready;
  assign host_bus.wdata   = wdata;
  assign host_bus.wvalid  = wvalid;
  assign wready           = host_bus.wready;
  assign bresp            = host_bus.bresp;
  assign bvalid           = host_bus.bvalid;
  assign host_bus.bready  = bready;
  assign host_bus.araddr  = araddr;
  assign host_bus.arvalid = arvalid;
  assign arready          = host_bus.arready;
  assign rdata            = host_bus.rdata;
  assign rresp            = host_bus.rresp;
  assign rvalid           = host_bus.rvalid;
  assign host_bus.rready  = rready;

  axil_reg_slice axil_reg_slice_inst (
    .clk   (clk),
    .reset (reset),
    .s     (host_bus),
    .m     (slice_bus)
  );

  ocl_slave_fsm ocl_slave_fsm_inst (
    .clk   (clk),
    .reset (reset),
    .axil  (slice_bus),
    .req   (req_bus)
  );

  cfg_slot_dispatch cfg_slot_dispatch_inst (
    .clk       (clk),
    .reset     (reset),
    .req       (req_bus),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/ocl_slave_fsm.sv ====
// access state machine with write priority, axi handshakes and okay responses
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

module ocl_slave_fsm (
  input wire      clk,
  input wire      reset,
  axil_if.sub     axil, // from the register slice
  cfg_req_if.fsm  req   // to the slot decoder
);

  import ocl_bridge_pkg::*;

  slv_state_e             state;
  slv_state_e             state_nxt;
  logic                   cyc_wr;    // current access is a write
  logic                   did_req;   // request already pulsed for this access
  logic                   req_go;    // fire the request this cycle
  logic                   req_valid; // write data present or any read
  logic                   rsp_ready; // b or r ready for the current access type
  logic                   cyc_done;  // ack for our own request
  ocl_addr_u              addr_q;    // one shared address copy
  logic [`CFG_DATA_W-1:0] rdata_q;

  assign req_valid = cyc_wr ? axil.wvalid : 1'b1;
  assign rsp_ready = cyc_wr ? axil.bready : axil.rready;
  assign cyc_done  = (state == SLV_CYC) && did_req && req.ack;

  // ------------------------------------------------------------
  // next state with aw checked first so writes win
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      SLV_IDLE: begin
        if (axil.awvalid)
          state_nxt = SLV_WR_ADDR;
        else if (axil.arvalid)
          state_nxt = SLV_CYC; // reads skip the address state
      end
      SLV_WR_ADDR: state_nxt = SLV_CYC;
      SLV_CYC: begin
        if (cyc_done)
          state_nxt = SLV_RESP;
      end
      SLV_RESP: begin
        if (rsp_ready)
          state_nxt = SLV_IDLE;
      end
      default: state_nxt = SLV_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= SLV_IDLE;
      cyc_wr       <= 1'b0;
      did_req      <= 1'b0;
      axil.awready <= 1'b0;
      axil.wready  <= 1'b0;
      axil.arready <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == SLV_IDLE)
        cyc_wr <= axil.awvalid; // latch the winner
      if (state == SLV_IDLE)
        did_req <= 1'b0;
      else if (req_go)
        did_req <= 1'b1;
      // single-cycle readies back into the slice
      axil.awready <= (state == SLV_IDLE) && (state_nxt == SLV_WR_ADDR);
      axil.wready  <= cyc_done && cyc_wr;
      axil.arready <= cyc_done && !cyc_wr;
    end
  end

  // address taken on the way out of idle and read data on ack
  always_ff @(posedge clk) begin
    if (state == SLV_IDLE)
      addr_q.raw <= axil.awvalid ? axil.awaddr : axil.araddr;
    if (cyc_done)
      rdata_q <= req.rdata;
  end

  // ------------------------------------------------------------
  // request and responses
  // ------------------------------------------------------------
  assign req_go     = (state == SLV_CYC) && req_valid && !did_req;
  assign req.req_wr = req_go && cyc_wr;
  assign req.req_rd = req_go && !cyc_wr;
  assign req.addr   = addr_q;
  assign req.wdata  = axil.wdata; // held by the w stage until wready

  assign axil.bvalid = (state == SLV_RESP) && cyc_wr;
  assign axil.bresp  = RESP_OKAY;
  assign axil.rvalid = (state == SLV_RESP) && !cyc_wr;
  assign axil.rdata  = rdata_q;
  assign axil.rresp  = RESP_OKAY;

  // responses wait for the slice to take them
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    axil.bvalid && !axil.bready |=> axil.bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    axil.rvalid && !axil.rready |=> axil.rvalid && $stable(axil.rdata));

endmodule

`default_nettype wire

// ==== ocl_cfg_bridge.f ====
+incdir+logic
logic/ocl_bridge_pkg.sv
logic/ocl_bridge_if.sv
logic/axil_reg_slice.sv
logic/ocl_slave_fsm.sv
logic/cfg_slot_dispatch.sv
logic/ocl_cfg_bridge.sv
verif/tb_clk_gen.sv
verif/tb_ocl_cfg_bridge.sv

// ==== verif/tb_clk_gen.sv ====
// tb_clk_gen: free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2.0) clk = ~clk; // 50% duty

endmodule

`default_nettype wire

// ==== verif/tb_ocl_cfg_bridge.sv ====
// testbench top: random host and target models, reference model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "ocl_bridge_cfg.svh"

module tb_ocl_cfg_bridge;

  import ocl_bridge_pkg::*;

  localparam int DW       = `CFG_DATA_W;
  localparam int NS       = `CFG_NUM_SLOTS;
  localparam int WORDS    = 64;  // words per target window
  localparam int CLK_NS   = 40;
  localparam int N_WRRD   = 40;  // write then read back
  localparam int N_UNMAP  = 30;
  localparam int N_MIX    = 150;
  localparam int N_SAME   = 40;  // aw and ar in the same cycle
  localparam int N_ACC    = 2 * N_WRRD + N_UNMAP + N_MIX + 2 * N_SAME;
  localparam int LIMIT_NS = N_ACC * 60 * CLK_NS + 5000; // 60 cycles per access plus margin

  logic             clk;
  logic             reset;
  logic [DW-1:0]    awaddr;
  logic             awvalid;
  logic             awready;
  logic [DW-1:0]    wdata;
  logic             wvalid;
  logic             wready;
  logic [1:0]       bresp;
  logic             bvalid;
  logic             bready;
  logic [DW-1:0]    araddr;
  logic             arvalid;
  logic             arready;
  logic [DW-1:0]    rdata;
  logic [1:0]       rresp;
  logic             rvalid;
  logic             rready;
  logic [DW-1:0]    cfg_addr;
  logic [DW-1:0]    cfg_wdata;
  logic [NS-1:0]    cfg_wr;
  logic [NS-1:0]    cfg_rd;
  logic [NS-1:0]    cfg_ack;
  logic [NS*DW-1:0] cfg_rdata;

  logic [DW-1:0] tgt_mem [NS][WORDS]; // what the targets hold
  logic [DW-1:0] exp_mem [NS][WORDS]; // reference copy
  logic [2*DW:0] strobe_q [$];        // {is_write, addr, wdata}, in bus order
  logic [31:0]   rnd_state = 32'h6211_e50f;
  int            test_errors;
  int            errors;
  int            tests_run;
  int            tests_failed;
  int            accesses;

  tb_clk_gen #(.PERIOD_NS(40.0)) tb_clk_gen_inst (.clk(clk));

  ocl_cfg_bridge ocl_cfg_bridge_inst (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_wr(cfg_wr), .cfg_rd(cfg_rd),
    .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
  );

  // xorshift32, one step per call
  function automatic logic [31:0] next_random();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  function automatic int slot_of(input logic [DW-1:0] a);
    return int'(a[`CFG_SLOT_SHIFT +: `CFG_SLOT_W]); // addr[24:8]
  endfunction

  function automatic int word_of(input logic [DW-1:0] a);
    return int'(a[`CFG_SLOT_SHIFT-1:2]);
  endfunction

  // upper bits random, the bridge ignores them
  function automatic logic [DW-1:0] pick_addr(input bit mapped);
    logic [`CFG_SLOT_W-1:0] slot;
    logic [31:0]            r;
    r = next_random();
    if (mapped)
      slot = `CFG_SLOT_W'(r % NS);
    else
      slot = `CFG_SLOT_W'(NS + r % ((1 << `CFG_SLOT_W) - NS)); // any empty window
    r = next_random();
    return {r[31:25], slot, r[7:2], 2'b00};
  endfunction

  task automatic note_mismatch(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] want);
    $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    test_errors++;
  endtask

  task automatic note_problem(input string what);
    $display("%0t %s", $time, what);
    test_errors++;
  endtask

  task automatic step();
    @(posedge clk);
    #2; // drive and sample just after the edge
  endtask

  // nothing ready, valid or strobing
  task automatic check_quiet();
    if (awready !== 1'b0) note_mismatch("awready", awready, 0);
    if (wready !== 1'b0) note_mismatch("wready", wready, 0);
    if (arready !== 1'b0) note_mismatch("arready", arready, 0);
    if (bvalid !== 1'b0) note_mismatch("bvalid", bvalid, 0);
    if (rvalid !== 1'b0) note_mismatch("rvalid", rvalid, 0);
    if (cfg_wr !== '0) note_mismatch("cfg_wr", cfg_wr, 0);
    if (cfg_rd !== '0) note_mismatch("cfg_rd", cfg_rd, 0);
  endtask

  task automatic idle_gap(input int n);
    repeat (n) begin
      step();
      if (bvalid !== 1'b0 || rvalid !== 1'b0)
        note_problem("response showed up with no access outstanding");
    end
  endtask

  task automatic end_test(input string name);
    $display("%-22s %4d accesses, %0d errors", name, accesses, test_errors);
    if (test_errors != 0)
      tests_failed++;
    errors      += test_errors;
    test_errors = 0;
    accesses    = 0;
    tests_run++;
  endtask

  // ------------------------------------------------------------
  // host: one write, one read or both at once, random b/r stalls
  // ------------------------------------------------------------
  task automatic run_access(input bit wr, input bit rd, input logic [DW-1:0] wa,
                            input logic [DW-1:0] wd, input logic [DW-1:0] ra);
    logic [DW-1:0] r_want;
    logic [DW-1:0] r_last;
    logic [1:0]    b_last;
    logic [1:0]    rr_last;
    bit            b_seen;
    bit            r_seen;
    bit            b_shown;  // bvalid has been high at least once
    bit            b_stall;
    bit            r_stall;
    bit            aw_go;
    bit            w_go;
    bit            ar_go;
    r_want  = `CFG_UNMAPPED_RDATA;
    r_last  = '0;
    b_last  = '0;
    rr_last = '0;
    b_seen  = !wr;
    r_seen  = !rd;
    b_shown = 1'b0;
    b_stall = 1'b0;
    r_stall = 1'b0;
    // reference model, write served first
    if (wr && slot_of(wa) < NS) begin
      exp_mem[slot_of(wa)][word_of(wa)] = wd;
      strobe_q.push_back({1'b1, wa, wd});
    end
    if (rd && slot_of(ra) < NS) begin
      r_want = exp_mem[slot_of(ra)][word_of(ra)];
      strobe_q.push_back({1'b0, ra, {DW{1'b0}}});
    end
    accesses += int'(wr) + int'(rd);
    awaddr  = wa;
    wdata   = wd;
    araddr  = ra;
    awvalid = wr;
    wvalid  = wr;
    arvalid = rd;
    while (!(b_seen && r_seen)) begin
      bready = (next_random() % 3) != 0; // stall about a third of the cycles
      rready = (next_random() % 3) != 0;
      // held responses must not move
      if (b_stall && bvalid !== 1'b1)
        note_problem("bvalid dropped before it was accepted");
      if (b_stall && bresp !== b_last)
        note_mismatch("bresp", bresp, b_last);
      if (r_stall && rvalid !== 1'b1)
        note_problem("rvalid dropped before it was accepted");
      if (r_stall && rdata !== r_last)
        note_mismatch("rdata", rdata, r_last);
      if (r_stall && rresp !== rr_last)
        note_mismatch("rresp", rresp, rr_last);
      if (rvalid === 1'b1 && wr && !b_shown)
        note_problem("read response arrived before the write response");
      if (bvalid === 1'b1)
        b_shown = 1'b1;
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      ar_go = arvalid && arready;
      if (bvalid && bready) begin
        if (b_seen)
          note_problem("write response with no write outstanding");
        if (bresp !== RESP_OKAY)
          note_mismatch("bresp", bresp, RESP_OKAY);
        b_seen = 1'b1;
      end
      if (rvalid && rready) begin
        if (r_seen)
          note_problem("read response with no read outstanding");
        if (rdata !== r_want)
          note_mismatch("rdata", rdata, r_want);
        if (rresp !== RESP_OKAY)
          note_mismatch("rresp", rresp, RESP_OKAY);
        r_seen = 1'b1;
      end
      b_stall = bvalid && !bready;
      r_stall = rvalid && !rready;
      b_last  = bresp;
      rr_last = rresp;
      r_last  = rdata;
      step();
      if (aw_go)
        awvalid = 1'b0;
      if (w_go)
        wvalid = 1'b0;
      if (ar_go)
        arvalid = 1'b0;
    end
    bready = 1'b0;
    rready = 1'b0;
    if (awvalid || wvalid || arvalid)
      note_problem("address or write data never accepted");
    if (strobe_q.size() != 0)
      note_problem("mapped access finished without a configuration strobe");
  endtask

  // ------------------------------------------------------------
  // targets, 64-word memories, ack 0 to 3 cycles after the strobe
  // ------------------------------------------------------------
  initial begin : targets
    logic [2*DW:0] want;
    logic [NS-1:0] want_wr;
    logic [NS-1:0] want_rd;
    int            slot;
    int            pend;     // slot owing an ack, -1 for none
    int unsigned   wait_cyc;
    cfg_ack   = '0;
    cfg_rdata = '0;
    pend      = -1;
    wait_cyc  = 0;
    forever begin
      @(posedge clk);
      #1;
      cfg_ack = '0; // single-cycle pulse
      if ((cfg_wr | cfg_rd) != '0) begin
        slot = 0;
        for (int i = 0; i < NS; i++)
          if (cfg_wr[i] || cfg_rd[i])
            slot = i;
        if ($countones({cfg_wr, cfg_rd}) != 1)
          note_problem("more than one configuration strobe at once");
        if (strobe_q.size() == 0) begin
          note_problem("configuration strobe with no mapped access pending");
        end else begin
          want    = strobe_q.pop_front();
          want_wr = '0;
          want_rd = '0;
          if (want[2*DW])
            want_wr[slot_of(want[2*DW-1:DW])] = 1'b1;
          else
            want_rd[slot_of(want[2*DW-1:DW])] = 1'b1;
          if (cfg_wr !== want_wr) note_mismatch("cfg_wr", cfg_wr, want_wr);
          if (cfg_rd !== want_rd) note_mismatch("cfg_rd", cfg_rd, want_rd);
          if (cfg_addr !== want[2*DW-1:DW])
            note_mismatch("cfg_addr", cfg_addr, want[2*DW-1:DW]);
          if (want[2*DW] && cfg_wdata !== want[DW-1:0])
            note_mismatch("cfg_wdata", cfg_wdata, want[DW-1:0]);
        end
        if (cfg_wr[slot])
          tgt_mem[slot][word_of(cfg_addr)] = cfg_wdata;
        else
          cfg_rdata[slot*DW +: DW] = tgt_mem[slot][word_of(cfg_addr)];
        pend     = slot;
        wait_cyc = next_random() % 4;
      end
      if (pend >= 0) begin
        if (wait_cyc == 0) begin
          cfg_ack[pend] = 1'b1;
          pend          = -1;
        end else begin
          wait_cyc--;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [DW-1:0] a;
    logic [DW-1:0] d;
    bit            wr;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    test_errors  = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    accesses     = 0;
    for (int s = 0; s < NS; s++)
      for (int w = 0; w < WORDS; w++) begin
        tgt_mem[s][w] = {16'hc0de, 8'(s), 8'(w)}; // slot and word in every entry
        exp_mem[s][w] = {16'hc0de, 8'(s), 8'(w)};
      end

    repeat (3) begin
      step();
      check_quiet();
    end
    reset = 1'b0;
    check_quiet(); // first cycle out of reset
    end_test("reset");

    for (int i = 0; i < N_WRRD; i++) begin
      a = pick_addr(1'b1);
      d = next_random();
      run_access(1'b1, 1'b0, a, d, '0);
      idle_gap(next_random() % 4);
      run_access(1'b0, 1'b1, '0, '0, a);
      idle_gap(next_random() % 4);
    end
    end_test("write_read");

    for (int i = 0; i < N_UNMAP; i++) begin
      a  = pick_addr(1'b0);
      wr = next_random() % 2;
      run_access(wr, !wr, a, next_random(), a); // dropped write or dead_beef read
      idle_gap(next_random() % 4);
    end
    end_test("unmapped");

    for (int i = 0; i < N_MIX; i++) begin
      a  = pick_addr((next_random() % 10) < 8); // 80% mapped
      wr = next_random() % 2;
      run_access(wr, !wr, a, next_random(), a);
      idle_gap(next_random() % 4);
    end
    end_test("random_mix");

    for (int i = 0; i < N_SAME; i++) begin
      a = pick_addr(1'b1);
      d = next_random();
      if (next_random() % 2)
        run_access(1'b1, 1'b1, a, d, a); // read must see the new word
      else
        run_access(1'b1, 1'b1, a, d, pick_addr((next_random() % 10) < 8));
      idle_gap(next_random() % 4);
    end
    end_test("write_read_same_cycle");

    for (int s = 0; s < NS; s++)
      for (int w = 0; w < WORDS; w++)
        if (tgt_mem[s][w] !== exp_mem[s][w])
          note_mismatch($sformatf("tgt_mem[%0d][%0d]", s, w), tgt_mem[s][w], exp_mem[s][w]);
    end_test("memory_contents");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    slv_state_e st;
    #(LIMIT_NS);
    st = ocl_cfg_bridge_inst.ocl_slave_fsm_inst.state;
    $display("watchdog expired at %0t, bridge FSM stuck in %s", $time, st.name());
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
